// File: mailbox_controller.sv
// polling FSM that fetches mailbox commands, runs the multiplier and writes results back
`timescale 1ns/1ps
`include "mult_settings.svh"

module mailbox_controller (
        input  logic                    CLOCK_50,
        input  logic                    rst_n,
        output mult_pkg::mem_req_t      fab_req,        // fabric RAM port
        input  logic [`MB_DATA_W-1:0]   fab_rdata,
        output logic                    start,          // one cycle strobe
        output mult_pkg::mul_job_t      job,
        input  logic                    done,
        input  logic [`PROD_W-1:0]      product,
        output logic                    job_done,       // high during WRITE_RES
        output mult_pkg::ctrl_state_t   state
);
        import mult_pkg::*;

        localparam int CNT_W = `RES_CNT_MSB - `RES_CNT_LSB + 1;

        logic [`MB_DATA_W-1:0]  cmd_q;          // command word as fetched
        logic [CNT_W-1:0]       job_cnt;        // completed jobs, wraps at 256

        // ==================================================================
        // state register and control
        // ==================================================================
        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        state    <= POLL;
                        start    <= 1'b0;
                        job_done <= 1'b0;
                        job      <= '0;
                        job_cnt  <= '0;
                end else begin
                        start    <= 1'b0;       // strobes by default
                        job_done <= 1'b0;
                        case (state)
                        POLL:   state <= FETCH;
                        FETCH:  state <= CHECK;
                        CHECK: begin
                                if (cmd_q[`GO_BIT]) begin
                                        job.a <= cmd_q[`CMD_A_MSB:`CMD_A_LSB];
                                        job.b <= cmd_q[`CMD_B_MSB:`CMD_B_LSB];
                                        start <= 1'b1;  // seen in first RUN cycle
                                        state <= RUN;
                                end else begin
                                        state <= POLL;  // nothing posted, poll again
                                end
                        end
                        RUN: begin
                                if (done) begin
                                        job_cnt  <= job_cnt + 1'b1;
                                        job_done <= 1'b1;
                                        state    <= WRITE_RES;
                                end
                        end
                        WRITE_RES: state <= CLEAR_GO;
                        CLEAR_GO:  state <= POLL;
                        default:   state <= POLL;
                        endcase
                end
        end

        // latch the word read in POLL
        always_ff @(posedge CLOCK_50) begin
                if (state == FETCH) begin
                        cmd_q <= fab_rdata;
                end
        end

        // ==================================================================
        // fabric port request, a read of CMD_ADDR unless writing back
        // ==================================================================
        always_comb begin
                fab_req.we    = 1'b0;
                fab_req.addr  = `MB_ADDR_W'(`CMD_ADDR);
                fab_req.wdata = '0;
                case (state)
                WRITE_RES: begin
                        fab_req.we   = 1'b1;
                        fab_req.addr = `MB_ADDR_W'(`RES_ADDR);
                        fab_req.wdata[`RES_PROD_MSB:`RES_PROD_LSB] = product;
                        fab_req.wdata[`RES_CNT_MSB:`RES_CNT_LSB]   = job_cnt;
                end
                CLEAR_GO: begin
                        // same operands back, go flag left at zero
                        fab_req.we   = 1'b1;
                        fab_req.wdata[`CMD_A_MSB:`CMD_A_LSB] = job.a;
                        fab_req.wdata[`CMD_B_MSB:`CMD_B_LSB] = job.b;
                end
                default: ;
                endcase
        end

        // job_done goes with the result write
        a_job_done_in_write: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                job_done |-> (state == WRITE_RES && fab_req.we))
                else $error("job_done outside WRITE_RES");

        // only the first RUN cycle may carry start
        a_no_restart: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                $past(state) == RUN |-> !start)
                else $error("start raised while waiting for done");

endmodule

// File: mailbox_ram.sv
// dual-port word RAM shared by the host port and the fabric mailbox controller
`timescale 1ns/1ps
`include "mult_settings.svh"

module mailbox_ram (
        input  logic                    clk,
        input  mult_pkg::mem_req_t      host_req,
        output logic [`MB_DATA_W-1:0]   host_rdata,
        input  mult_pkg::mem_req_t      fab_req,
        output logic [`MB_DATA_W-1:0]   fab_rdata
);
        import mult_pkg::*;

        logic [`MB_DATA_W-1:0] mem [`MB_DEPTH];        // no reset on contents

        // ==================================================================
        // writes, host port last so it wins on an address clash
        // ==================================================================
        always_ff @(posedge clk) begin
                if (fab_req.we) begin
                        mem[fab_req.addr] <= fab_req.wdata;
                end
                if (host_req.we) begin
                        mem[host_req.addr] <= host_req.wdata;
                end
        end

        // registered reads, one cycle latency on both ports
        // old data is returned when a port reads the word it writes
        always_ff @(posedge clk) begin
                host_rdata <= mem[host_req.addr];
                fab_rdata  <= mem[fab_req.addr];
        end

endmodule

// File: mult_mailbox_top.sv
// fabric top level: mailbox RAM, controller, multiplier and six hex displays, host port exposed
`timescale 1ns/1ps
`include "mult_settings.svh"

module mult_mailbox_top (
        input  logic                    CLOCK_50,
        input  logic                    rst_n,
        input  mult_pkg::mem_req_t      host_req,       // host side RAM port
        output logic [`MB_DATA_W-1:0]   host_rdata,
        output logic                    job_done,
        output logic [7:0]              HEX0,
        output logic [7:0]              HEX1,
        output logic [7:0]              HEX2,
        output logic [7:0]              HEX3,
        output logic [7:0]              HEX4,
        output logic [7:0]              HEX5
);
        import mult_pkg::*;

        // ==================================================================
        // internal connections
        // ==================================================================
        mem_req_t               fab_req;
        logic [`MB_DATA_W-1:0]  fab_rdata;
        logic                   mul_start;
        logic                   mul_done;
        mul_job_t               job;
        logic [`PROD_W-1:0]     product;
        ctrl_state_t            ctrl_state;
        mul_state_t             mul_state;

        mailbox_ram ram_i (
                .clk        (CLOCK_50),
                .host_req   (host_req),
                .host_rdata (host_rdata),
                .fab_req    (fab_req),
                .fab_rdata  (fab_rdata)
        );

        mailbox_controller ctrl_i (
                .CLOCK_50  (CLOCK_50),
                .rst_n     (rst_n),
                .fab_req   (fab_req),
                .fab_rdata (fab_rdata),
                .start     (mul_start),
                .job       (job),
                .done      (mul_done),
                .product   (product),
                .job_done  (job_done),
                .state     (ctrl_state)
        );

        shift_add_multiplier mult_i (
                .CLOCK_50 (CLOCK_50),
                .rst_n    (rst_n),
                .start    (mul_start),
                .job      (job),
                .product  (product),
                .done     (mul_done),
                .state    (mul_state)
        );

        // displays, state digits carry the dot
        seg7_decoder hex0_i (.digit(job.a),        .dot(1'b0), .seg(HEX0));
        seg7_decoder hex1_i (.digit(job.b),        .dot(1'b0), .seg(HEX1));
        seg7_decoder hex2_i (.digit(mul_state),    .dot(1'b1), .seg(HEX2));
        seg7_decoder hex3_i (.digit(ctrl_state),   .dot(1'b1), .seg(HEX3));
        seg7_decoder hex4_i (.digit(product[3:0]), .dot(1'b0), .seg(HEX4));
        seg7_decoder hex5_i (.digit(product[7:4]), .dot(1'b0), .seg(HEX5));

endmodule

// File: mult_pkg.sv
// shared struct and enum types for the mailbox multiplier, imported by RTL and testbench
`include "mult_settings.svh"

package mult_pkg;

        // ==================================================================
        // RAM port request
        // ==================================================================
        typedef struct packed {
                logic                   we;     // write when set, read otherwise
                logic [`MB_ADDR_W-1:0]  addr;
                logic [`MB_DATA_W-1:0]  wdata;
        } mem_req_t;                            // 37 bits

        // operands handed to the multiplier
        typedef struct packed {
                logic [`OPND_W-1:0]     b;      // multiplier
                logic [`OPND_W-1:0]     a;      // multiplicand
        } mul_job_t;

        // ==================================================================
        // state codes, 4 bits wide so they go straight to a hex digit
        // ==================================================================
        typedef enum logic [3:0] {
                POLL      = 4'd0,       // read request for the command word
                FETCH     = 4'd1,       // read data comes back
                CHECK     = 4'd2,       // look at the go flag
                RUN       = 4'd3,       // multiplier working
                WRITE_RES = 4'd4,       // product and count to RAM
                CLEAR_GO  = 4'd5        // hand the mailbox back to the host
        } ctrl_state_t;

        typedef enum logic [3:0] {
                IDLE = 4'd0,
                BUSY = 4'd1,
                DONE = 4'd2             // one cycle, done strobe high
        } mul_state_t;

endpackage

// File: mult_settings.svh
// RAM geometry, operand widths and mailbox word layout, included by the package and RTL
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// ======================================================================
// mailbox RAM geometry
// ======================================================================
`define MB_ADDR_W       4       // word address bits
`define MB_DEPTH        16      // words in the shared RAM
`define MB_DATA_W       32      // host side word width

// ======================================================================
// multiplier widths
// ======================================================================
`define OPND_W          4
`define PROD_W          8
`define MUL_STEPS       4       // one partial product per cycle

// mailbox word addresses
`define CMD_ADDR        0
`define RES_ADDR        1

// command word, written by the host
`define CMD_A_LSB       0
`define CMD_A_MSB       3
`define CMD_B_LSB       4
`define CMD_B_MSB       7
`define GO_BIT          31      // host sets, fabric clears

// result word, written by the fabric
`define RES_PROD_LSB    0
`define RES_PROD_MSB    7
`define RES_CNT_LSB     8
`define RES_CNT_MSB     15      // everything above stays zero

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# builds the mailbox multiplier testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
        --top-module tb_mult_mailbox -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -qx "No errors" sim.log; then
        echo "simulation passed"
        exit 0
fi
echo "simulation failed"
exit 1

// File: seg7_decoder.sv
// hex digit to active-low seven-segment pattern, decimal point on bit 7
`timescale 1ns/1ps

module seg7_decoder (
        input  logic [3:0]      digit,
        input  logic            dot,
        output logic [7:0]      seg     // {dp, g, f, e, d, c, b, a}, low lights
);
        logic [6:0] segs;

        always_comb begin
                case (digit)
                4'h0:    segs = 7'h40;
                4'h1:    segs = 7'h79;
                4'h2:    segs = 7'h24;
                4'h3:    segs = 7'h30;
                4'h4:    segs = 7'h19;
                4'h5:    segs = 7'h12;
                4'h6:    segs = 7'h02;
                4'h7:    segs = 7'h78;
                4'h8:    segs = 7'h00;
                4'h9:    segs = 7'h10;
                4'ha:    segs = 7'h08;
                4'hb:    segs = 7'h03;  // lower case b
                4'hc:    segs = 7'h46;
                4'hd:    segs = 7'h21;  // lower case d
                4'he:    segs = 7'h06;
                default: segs = 7'h0e;  // F
                endcase
        end

        assign seg = {~dot, segs};

endmodule

// File: shift_add_multiplier.sv
// sequential shift-and-add multiplier, one partial product per cycle, start/done strobes
`timescale 1ns/1ps
`include "mult_settings.svh"

module shift_add_multiplier (
        input  logic                    CLOCK_50,
        input  logic                    rst_n,
        input  logic                    start,
        input  mult_pkg::mul_job_t      job,
        output logic [`PROD_W-1:0]      product,        // accumulator, held after done
        output logic                    done,
        output mult_pkg::mul_state_t    state
);
        import mult_pkg::*;

        localparam int CNT_W = $clog2(`MUL_STEPS + 1);

        logic [`PROD_W-1:0]     mcand;  // shifted multiplicand
        logic [`OPND_W-1:0]     mplr;   // multiplier, lsb is current bit
        logic [CNT_W-1:0]       step;   // partial products taken
        logic                   load;

        assign load = start && (state != BUSY);

        // ==================================================================
        // control and accumulator
        // ==================================================================
        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        state   <= IDLE;
                        done    <= 1'b0;
                        step    <= '0;
                        product <= '0;
                end else begin
                        done <= 1'b0;
                        if (load) begin
                                // accumulator restarts from partial product 0
                                product <= job.b[0] ? `PROD_W'(job.a) : '0;
                                step    <= CNT_W'(1);
                                state   <= BUSY;
                        end else begin
                                case (state)
                                BUSY: begin
                                        if (mplr[0]) begin
                                                product <= product + mcand;
                                        end
                                        step <= step + 1'b1;
                                        if (step == CNT_W'(`MUL_STEPS - 1)) begin
                                                state <= DONE;  // last bit added
                                                done  <= 1'b1;
                                        end
                                end
                                DONE:    state <= IDLE;
                                default: state <= IDLE;
                                endcase
                        end
                end
        end

        // operand shifters
        always_ff @(posedge CLOCK_50) begin
                if (load) begin
                        mcand <= `PROD_W'(job.a) << 1;
                        mplr  <= job.b >> 1;
                end else if (state == BUSY) begin
                        mcand <= mcand << 1;
                        mplr  <= mplr >> 1;
                end
        end

        a_done_latency: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                start |-> ##(`MUL_STEPS) done)
                else $error("done not MUL_STEPS cycles after start");

        a_no_start_busy: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                start |-> state != BUSY)
                else $error("start while multiplier busy");

endmodule

// File: sources.f
+incdir+.
mult_pkg.sv
mailbox_ram.sv
mailbox_controller.sv
shift_add_multiplier.sv
seg7_decoder.sv
mult_mailbox_top.sv
tb_mult_mailbox.sv

// File: tb_mult_mailbox.sv
// testbench for mult_mailbox_top that plays the host on the RAM port and checks results with assertions
`timescale 1ns/1ps
`include "mult_settings.svh"

module tb_mult_mailbox;
        import mult_pkg::*;

        localparam int CLK_PERIOD   = 4;
        localparam int RESET_CYCLES = 8;
        localparam int N_JOBS       = 20;
        localparam int QUIET_CYCLES = 40;
        localparam int WDOG_CYCLES  = N_JOBS * 200 + 500;      // per job budget plus margin

        logic clk;
        logic rst_n;
        mem_req_t host_req;
        logic [`MB_DATA_W-1:0] host_rdata;
        logic job_done;
        logic [7:0] HEX0, HEX1, HEX2, HEX3, HEX4, HEX5;

        logic [31:0] lfsr;
        logic idle_chk, chk_job, chk_quiet, quiet;     // check windows driven off the edge
        logic [7:0] exp_prod, got_prod, exp_cnt, got_cnt;
        logic [`MB_DATA_W-1:0] exp_cmd, got_cmd, exp_res, got_res;
        logic [7:0] exp_hex0, exp_hex1, exp_hex4, exp_hex5;
        int err_reset, err_result, err_cmd, err_hex, err_quiet;

        mult_mailbox_top dut_i (
                .CLOCK_50   (clk),
                .rst_n      (rst_n),
                .host_req   (host_req),
                .host_rdata (host_rdata),
                .job_done   (job_done),
                .HEX0 (HEX0), .HEX1 (HEX1), .HEX2 (HEX2),
                .HEX3 (HEX3), .HEX4 (HEX4), .HEX5 (HEX5)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // ==================================================================
        // helpers
        // ==================================================================
        // x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic rand_nibble(output logic [3:0] n);
                for (int i = 0; i < 4; i++) begin
                        lfsr = lfsr_next(lfsr);         // one step per bit
                        n[i] = lfsr[0];
                end
        endtask

        // segments lit per digit {g..a} active high and inverted for the board
        function automatic logic [7:0] hex_pattern(input logic [3:0] d, input logic dot);
                logic [6:0] lit;
                case (d)
                4'h0:    lit = 7'h3f;
                4'h1:    lit = 7'h06;
                4'h2:    lit = 7'h5b;
                4'h3:    lit = 7'h4f;
                4'h4:    lit = 7'h66;
                4'h5:    lit = 7'h6d;
                4'h6:    lit = 7'h7d;
                4'h7:    lit = 7'h07;
                4'h8:    lit = 7'h7f;
                4'h9:    lit = 7'h6f;
                4'ha:    lit = 7'h77;
                4'hb:    lit = 7'h7c;
                4'hc:    lit = 7'h39;
                4'hd:    lit = 7'h5e;
                4'he:    lit = 7'h79;
                default: lit = 7'h71;
                endcase
                return {~dot, ~lit};
        endfunction

        task automatic host_write(input int addr, input logic [`MB_DATA_W-1:0] data);
                @(posedge clk);
                #1;
                host_req.we    = 1'b1;
                host_req.addr  = `MB_ADDR_W'(addr);
                host_req.wdata = data;
                @(posedge clk);
                #1 host_req.we = 1'b0;
        endtask

        // data comes back one cycle after the request
        task automatic host_read(input int addr, output logic [`MB_DATA_W-1:0] data);
                @(posedge clk);
                #1;
                host_req.we    = 1'b0;
                host_req.addr  = `MB_ADDR_W'(addr);
                host_req.wdata = '0;
                @(posedge clk);
                #1 data = host_rdata;
        endtask

        task automatic run_job(input logic [3:0] a, input logic [3:0] b);
                logic [`MB_DATA_W-1:0] word;
                logic [`MB_DATA_W-1:0] res_word;
                word = '0;
                word[`CMD_A_MSB:`CMD_A_LSB] = a;
                word[`CMD_B_MSB:`CMD_B_LSB] = b;
                exp_cmd = word;                 // go flag comes back clear
                word[`GO_BIT] = 1'b1;
                host_write(`CMD_ADDR, word);
                @(posedge clk);
                #1;
                while (!job_done) begin
                        @(posedge clk);
                        #1;
                end
                repeat (2) @(posedge clk);      // let result and go clear land
                host_read(`RES_ADDR, res_word);
                host_read(`CMD_ADDR, got_cmd);
                exp_prod = 8'(a) * 8'(b);
                exp_cnt  = exp_cnt + 8'd1;
                got_prod = res_word[`RES_PROD_MSB:`RES_PROD_LSB];
                got_cnt  = res_word[`RES_CNT_MSB:`RES_CNT_LSB];
                exp_res  = '0;                  // upper bits stay zero
                exp_res[`RES_PROD_MSB:`RES_PROD_LSB] = exp_prod;
                exp_res[`RES_CNT_MSB:`RES_CNT_LSB]   = exp_cnt;
                exp_hex0 = hex_pattern(a, 1'b0);
                exp_hex1 = hex_pattern(b, 1'b0);
                exp_hex4 = hex_pattern(exp_prod[3:0], 1'b0);
                exp_hex5 = hex_pattern(exp_prod[7:4], 1'b0);
                chk_job = 1'b1;                 // one sampled cycle
                @(posedge clk);
                #1 chk_job = 1'b0;
        endtask

        // ==================================================================
        // checks
        // ==================================================================
        a_idle_done: assert property (@(posedge clk) (idle_chk || quiet) |-> !job_done)
                else begin
                        if ($sampled(quiet)) begin
                                err_quiet++;
                        end else begin
                                err_reset++;
                        end
                        $display("[ERROR] no_job: expected job_done 0 actual 1");
                end
        a_prod: assert property (@(posedge clk) chk_job |-> got_prod == exp_prod)
                else begin
                        err_result++;
                        $display("[ERROR] product: expected %h actual %h", exp_prod, got_prod);
                end
        a_count: assert property (@(posedge clk) chk_job |-> got_cnt == exp_cnt)
                else begin
                        err_result++;
                        $display("[ERROR] job_count: expected %h actual %h", exp_cnt, got_cnt);
                end
        a_cmd: assert property (@(posedge clk) chk_job |-> got_cmd == exp_cmd)
                else begin
                        err_cmd++;
                        $display("[ERROR] cmd_readback: expected %h actual %h", exp_cmd, got_cmd);
                end
        a_hex_opnd: assert property (@(posedge clk) (idle_chk || chk_job) |->
                        HEX0 == exp_hex0 && HEX1 == exp_hex1)
                else begin
                        err_hex++;
                        $display("[ERROR] hex_operands: expected %h%h actual %h%h",
                                 exp_hex1, exp_hex0, $sampled(HEX1), $sampled(HEX0));
                end
        a_hex_prod: assert property (@(posedge clk) (idle_chk || chk_job) |->
                        HEX4 == exp_hex4 && HEX5 == exp_hex5)
                else begin
                        err_hex++;
                        $display("[ERROR] hex_product: expected %h%h actual %h%h",
                                 exp_hex5, exp_hex4, $sampled(HEX5), $sampled(HEX4));
                end
        a_hex_dots: assert property (@(posedge clk) chk_job |-> !HEX2[7] && !HEX3[7])
                else begin
                        err_hex++;
                        $display("[ERROR] hex_dots: expected 00 actual %b%b",
                                 $sampled(HEX3[7]), $sampled(HEX2[7]));
                end
        a_res_kept: assert property (@(posedge clk) chk_quiet |-> got_res == exp_res)
                else begin
                        err_quiet++;
                        $display("[ERROR] res_unchanged: expected %h actual %h", exp_res, got_res);
                end

        // ==================================================================
        // stimulus
        // ==================================================================
        initial begin
                logic [3:0] a;
                logic [3:0] b;
                logic [`MB_DATA_W-1:0] word;
                int total;
                rst_n = 1'b0;
                host_req.we    = 1'b1;          // clear the command word during reset
                host_req.addr  = `MB_ADDR_W'(`CMD_ADDR);
                host_req.wdata = '0;
                lfsr = 32'h9a9ecced;
                {idle_chk, chk_job, chk_quiet, quiet} = '0;
                {exp_prod, got_prod, exp_cnt, got_cnt} = '0;
                {exp_cmd, got_cmd, exp_res, got_res} = '0;
                {err_reset, err_result, err_cmd, err_hex, err_quiet} = '0;
                exp_hex0 = hex_pattern(4'h0, 1'b0);
                exp_hex1 = exp_hex0;
                exp_hex4 = exp_hex0;
                exp_hex5 = exp_hex0;
                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                rst_n       = 1'b1;
                host_req.we = 1'b0;
                idle_chk    = 1'b1;             // reset values on the displays
                repeat (10) @(posedge clk);
                #1 idle_chk = 1'b0;

                for (int j = 0; j < N_JOBS; j++) begin
                        rand_nibble(a);
                        rand_nibble(b);
                        run_job(a, b);
                end

                // command without the go flag should leave the fabric idle
                rand_nibble(a);
                rand_nibble(b);
                word = '0;
                word[`CMD_A_MSB:`CMD_A_LSB] = a;
                word[`CMD_B_MSB:`CMD_B_LSB] = b;
                host_write(`CMD_ADDR, word);
                quiet = 1'b1;
                repeat (QUIET_CYCLES) @(posedge clk);
                #1 quiet = 1'b0;
                host_read(`RES_ADDR, got_res);
                chk_quiet = 1'b1;
                @(posedge clk);
                #1 chk_quiet = 1'b0;
                @(posedge clk);

                total = err_reset + err_result + err_cmd + err_hex + err_quiet;
                $display("error counts: reset %0d, result %0d, command %0d, display %0d, quiet %0d",
                         err_reset, err_result, err_cmd, err_hex, err_quiet);
                if (total == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

        // watchdog
        initial begin
                #(WDOG_CYCLES * CLK_PERIOD);
                $display("timeout: job_done never came back, simulation stopped");
                $display("Errors found");
                $finish;
        end

endmodule
